// ==== all.f ====
+incdir+include
hw/id_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/operand_resolve.sv
hw/id_stage_top.sv
testbench/tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_id_stage -Mdir obj_dir -f all.f
./obj_dir/Vtb_id_stage | tee sim.log

# the testbench prints the pass line only when every check passed
grep -q "^NO ERRORS$" sim.log

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/1ps
`include "id_cfg.svh"

module tb_id_stage
    import id_pkg::*;
();

    localparam int TEST_CYCLES = 80;   // reset, preload and test cycles

    logic    clk;
    logic    rst_i;
    logic    inst_valid_i;
    word_t   pc_i;
    word_t   inst_i;
    reg_wr_t ex_fwd_i;
    alu_op_t ex_alu_op_i;
    reg_wr_t mem_fwd_i;
    reg_wr_t wb_i;
    logic    stall_o;
    branch_t branch_o;
    logic    ex_valid_o;
    id_ex_t  ex_o;

    word_t       ref_regs [`ID_NUM_REGS];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          tests_failed = 0;

    id_stage_top i_id_stage_top (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .ex_fwd_i     (ex_fwd_i),
        .ex_alu_op_i  (ex_alu_op_i),
        .mem_fwd_i    (mem_fwd_i),
        .wb_i         (wb_i),
        .stall_o      (stall_o),
        .branch_o     (branch_o),
        .ex_valid_o   (ex_valid_o),
        .ex_o         (ex_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 20 * 2);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES * 2);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic word_t reg_val(input reg_addr_t a);
        return (a == 5'd0) ? 32'd0 : ref_regs[a];   // r0 always zero
    endfunction

    function automatic word_t r_inst(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sh,
                                     input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_inst(input logic [5:0] opc, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic word_t j_inst(input logic [5:0] opc, input logic [25:0] idx);
        return {opc, idx};
    endfunction

    function automatic word_t pc_rel(input word_t pc, input logic [15:0] off);
        return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
    endfunction

    function automatic id_ex_t make_ex(input alu_op_t op, input alu_sel_t sel, input word_t o1,
                                       input word_t o2, input logic we, input reg_addr_t wa,
                                       input word_t link);
        id_ex_t e;
        e.alu_op    = op;
        e.alu_sel   = sel;
        e.operand_1 = o1;
        e.operand_2 = o2;
        e.wr_en     = we;
        e.wr_addr   = wa;
        e.link_addr = link;
        return e;
    endfunction

    function automatic branch_t make_br(input logic taken, input word_t target);
        branch_t b;
        b.taken  = taken;
        b.target = target;
        return b;
    endfunction

    task automatic check_ex(input id_ex_t got, input id_ex_t exp, input string what);
        id_ex_t g;
        g = got;
        if (!exp.wr_en) begin
            g.wr_addr = exp.wr_addr;    // destination unused without a write
        end
        checks++;
        if (g !== exp) begin
            errors++;
            $display("Error %0t: %s ex_o got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_branch(input branch_t got, input branch_t exp, input string what);
        checks++;
        if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
            errors++;
            $display("Error %0t: %s branch got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int start);
        tests++;
        if (errors == start) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start);
        end
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        wb_i = '{en: 1'b1, addr: a, data: d};
        @(posedge clk);
        #2;
        wb_i = '0;
        if (a != 5'd0) begin
            ref_regs[a] = d;
        end
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic run_inst(input word_t pc, input word_t inst, input id_ex_t exp_ex,
                            input branch_t exp_br, input string what);
        inst_valid_i = 1'b1;
        pc_i         = pc;
        inst_i       = inst;
        @(negedge clk);
        check_level(stall_o, 1'b0, $sformatf("%s stall", what));
        check_branch(branch_o, exp_br, what);
        @(posedge clk);
        #2;
        check_level(ex_valid_o, 1'b1, $sformatf("%s valid", what));
        check_ex(ex_o, exp_ex, what);
    endtask

    task automatic alu_r(input logic [5:0] fn, input alu_op_t op, input alu_sel_t sel,
                         input reg_addr_t rs, input reg_addr_t rt, input reg_addr_t rd);
        run_inst(32'h0000_0100, r_inst(rs, rt, rd, 5'd0, fn),
                 make_ex(op, sel, reg_val(rs), reg_val(rt), 1'b1, rd, '0), '0, "r-type");
    endtask

    task automatic alu_i(input logic [5:0] opc, input alu_op_t op, input alu_sel_t sel,
                         input reg_addr_t rs, input reg_addr_t rt, input logic [15:0] imm,
                         input word_t ext);
        run_inst(32'h0000_0104, i_inst(opc, rs, rt, imm),
                 make_ex(op, sel, reg_val(rs), ext, 1'b1, rt, '0), '0, "i-type");
    endtask

    task automatic test_alu_decode();
        int          start;
        logic [15:0] imm;
        start = errors;
        imm   = 16'($urandom()) | 16'h8000;   // top bit set so the extension shows
        alu_r(fn_or,   alu_or,  sel_logic, 5'd1,  5'd2,  5'd3);
        alu_r(fn_and,  alu_and, sel_logic, 5'd4,  5'd5,  5'd6);
        alu_r(fn_nor,  alu_nor, sel_logic, 5'd7,  5'd8,  5'd9);
        alu_r(fn_addu, alu_add, sel_arith, 5'd10, 5'd11, 5'd12);
        alu_r(fn_subu, alu_sub, sel_arith, 5'd13, 5'd14, 5'd15);
        alu_r(fn_slt,  alu_slt, sel_arith, 5'd16, 5'd17, 5'd18);
        alu_i(op_ori,   alu_or,  sel_logic, 5'd7,  5'd8,  imm, {16'h0000, imm});
        alu_i(op_andi,  alu_and, sel_logic, 5'd9,  5'd10, imm, {16'h0000, imm});
        alu_i(op_xori,  alu_xor, sel_logic, 5'd11, 5'd12, imm, {16'h0000, imm});
        alu_i(op_addiu, alu_add, sel_arith, 5'd19, 5'd20, imm, {{16{imm[15]}}, imm});
        imm = 16'($urandom()) | 16'h8000;   // negative immediate
        alu_i(op_slti,  alu_slt, sel_arith, 5'd13, 5'd14, imm, {{16{imm[15]}}, imm});
        alu_i(op_lui,   alu_or,  sel_logic, 5'd0,  5'd15, imm, {imm, 16'h0000});
        run_inst(32'h0000_0130, r_inst(5'd0, 5'd16, 5'd17, 5'd5, fn_sll),
                 make_ex(alu_sll, sel_shift, 32'd5, reg_val(5'd16), 1'b1, 5'd17, '0),
                 '0, "sll");
        end_test("alu decode", start);
    endtask

    task automatic test_forwarding();
        int    start;
        word_t a;
        word_t b;
        start = errors;
        a     = $urandom();
        b     = $urandom();
        ex_fwd_i  = '{en: 1'b1, addr: 5'd1, data: a};
        mem_fwd_i = '{en: 1'b1, addr: 5'd1, data: b};
        run_inst(32'h0000_0180, r_inst(5'd1, 5'd2, 5'd13, 5'd0, fn_addu),
                 make_ex(alu_add, sel_arith, a, reg_val(5'd2), 1'b1, 5'd13, '0), '0, "ex fwd");
        ex_fwd_i  = '{en: 1'b1, addr: 5'd5, data: a};
        mem_fwd_i = '{en: 1'b1, addr: 5'd2, data: b};
        run_inst(32'h0000_0184, r_inst(5'd1, 5'd2, 5'd13, 5'd0, fn_or),
                 make_ex(alu_or, sel_logic, reg_val(5'd1), b, 1'b1, 5'd13, '0), '0, "mem fwd");
        ex_fwd_i  = '0;
        mem_fwd_i = '0;
        wb_i      = '{en: 1'b1, addr: 5'd0, data: b};   // r0 write must not show
        run_inst(32'h0000_0188, r_inst(5'd0, 5'd2, 5'd13, 5'd0, fn_or),
                 make_ex(alu_or, sel_logic, '0, reg_val(5'd2), 1'b1, 5'd13, '0), '0, "r0");
        wb_i = '{en: 1'b1, addr: 5'd9, data: a};   // write-back in the same cycle
        run_inst(32'h0000_018c, r_inst(5'd9, 5'd0, 5'd13, 5'd0, fn_addu),
                 make_ex(alu_add, sel_arith, a, '0, 1'b1, 5'd13, '0), '0, "wb bypass");
        wb_i        = '0;
        ref_regs[9] = a;
        end_test("forwarding", start);
    endtask

    task automatic test_load_use();
        int    start;
        word_t ld;
        word_t pc;
        word_t inst;
        start = errors;
        ld    = $urandom();
        pc    = 32'h0000_0200;
        inst  = i_inst(op_beq, 5'd4, 5'd4, 16'h0010);
        ex_alu_op_i  = alu_lw;
        ex_fwd_i     = '{en: 1'b1, addr: 5'd4, data: 32'hdead_beef};  // load data not ready
        inst_valid_i = 1'b1;
        pc_i         = pc;
        inst_i       = inst;
        @(negedge clk);
        check_level(stall_o, 1'b1, "load-use stall");
        check_level(branch_o.taken, 1'b0, "taken during stall");
        @(posedge clk);
        #2;
        check_level(ex_valid_o, 1'b0, "bubble valid");
        check_ex(ex_o, '0, "bubble");
        // the load has moved on to mem
        ex_alu_op_i = alu_nop;
        ex_fwd_i    = '0;
        mem_fwd_i   = '{en: 1'b1, addr: 5'd4, data: ld};
        run_inst(pc, inst, make_ex(alu_beq, sel_jump_branch, ld, ld, 1'b0, 5'd0, '0),
                 make_br(1'b1, pc_rel(pc, 16'h0010)), "held beq");
        mem_fwd_i = '0;
        end_test("load-use stall", start);
    endtask

    task automatic test_branches();
        int          start;
        word_t       pc;
        word_t       t;
        logic [25:0] idx;
        start = errors;
        pc    = 32'h2fff_fffc;   // pc+4 crosses into the next region
        run_inst(pc, i_inst(op_beq, 5'd5, 5'd5, 16'hfff0),
                 make_ex(alu_beq, sel_jump_branch, reg_val(5'd5), reg_val(5'd5), 1'b0, 5'd0, '0),
                 make_br(1'b1, pc_rel(pc, 16'hfff0)), "beq taken");
        run_inst(pc, i_inst(op_beq, 5'd5, 5'd6, 16'h0024),
                 make_ex(alu_beq, sel_jump_branch, reg_val(5'd5), reg_val(5'd6), 1'b0, 5'd0, '0),
                 make_br(reg_val(5'd5) == reg_val(5'd6), pc_rel(pc, 16'h0024)), "beq");
        run_inst(pc, i_inst(op_bne, 5'd5, 5'd6, 16'h0024),
                 make_ex(alu_bne, sel_jump_branch, reg_val(5'd5), reg_val(5'd6), 1'b0, 5'd0, '0),
                 make_br(reg_val(5'd5) != reg_val(5'd6), pc_rel(pc, 16'h0024)), "bne");
        run_inst(pc, i_inst(op_bne, 5'd5, 5'd5, 16'h0024),
                 make_ex(alu_bne, sel_jump_branch, reg_val(5'd5), reg_val(5'd5), 1'b0, 5'd0, '0),
                 make_br(1'b0, pc_rel(pc, 16'h0024)), "bne not taken");
        idx = 26'($urandom());
        t   = pc + 32'd4;
        run_inst(pc, j_inst(op_j, idx), make_ex(alu_j, sel_jump_branch, '0, '0, 1'b0, 5'd0, '0),
                 make_br(1'b1, {t[31:28], idx, 2'b00}), "j");
        run_inst(pc, j_inst(op_jal, idx),
                 make_ex(alu_jal, sel_jump_branch, '0, '0, 1'b1, 5'(`ID_LINK_REG), pc + 32'd8),
                 make_br(1'b1, {t[31:28], idx, 2'b00}), "jal");
        t        = $urandom() & 32'hffff_fffc;
        ex_fwd_i = '{en: 1'b1, addr: 5'd7, data: t};
        run_inst(pc, r_inst(5'd7, 5'd0, 5'd0, 5'd0, fn_jr),
                 make_ex(alu_jr, sel_jump_branch, t, '0, 1'b0, 5'd0, '0), make_br(1'b1, t), "jr");
        ex_fwd_i = '0;
        end_test("branches and jumps", start);
    endtask

    task automatic test_store_unknown_reset();
        int          start;
        logic [15:0] imm;
        start = errors;
        imm   = 16'($urandom());
        run_inst(32'h0000_0300, i_inst(op_sw, 5'd3, 5'd8, imm),
                 make_ex(alu_sw, sel_load_store, reg_val(5'd3), reg_val(5'd8), 1'b0, 5'd0, '0),
                 '0, "sw");
        run_inst(32'h0000_0304, {6'h3f, 5'd3, 5'd4, 16'h0000},
                 make_ex(alu_nop, sel_nop, '0, '0, 1'b0, 5'd0, '0), '0, "unknown opcode");
        // reset with a jr waiting behind a load
        rst_i       = 1'b1;
        inst_i      = r_inst(5'd7, 5'd0, 5'd0, 5'd0, fn_jr);
        ex_alu_op_i = alu_lw;
        ex_fwd_i    = '{en: 1'b1, addr: 5'd7, data: 32'h0000_0400};
        @(negedge clk);
        check_level(stall_o, 1'b0, "stall in reset");
        check_level(branch_o.taken, 1'b0, "taken in reset");
        @(posedge clk);
        #2;
        rst_i        = 1'b0;
        inst_valid_i = 1'b0;
        ex_alu_op_i  = alu_nop;
        ex_fwd_i     = '0;
        check_level(ex_valid_o, 1'b0, "valid after reset");
        check_ex(ex_o, '0, "ex_o after reset");
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        run_inst(32'h0000_0400, i_inst(op_addiu, 5'd0, 5'd20, imm),
                 make_ex(alu_add, sel_arith, '0, {{16{imm[15]}}, imm}, 1'b1, 5'd20, '0),
                 '0, "stream 1");
        run_inst(32'h0000_0404, i_inst(op_ori, 5'd0, 5'd21, imm),
                 make_ex(alu_or, sel_logic, '0, {16'h0000, imm}, 1'b1, 5'd21, '0), '0, "stream 2");
        run_inst(32'h0000_0408, r_inst(5'd9, 5'd1, 5'd22, 5'd0, fn_or),
                 make_ex(alu_or, sel_logic, reg_val(5'd9), reg_val(5'd1), 1'b1, 5'd22, '0),
                 '0, "stream 3");
        inst_valid_i = 1'b0;
        end_test("store, unknown and reset", start);
    endtask

    initial begin
        void'($urandom(32'h8e2f_342d));
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        ex_fwd_i     = '0;
        ex_alu_op_i  = alu_nop;
        mem_fwd_i    = '0;
        wb_i         = '0;
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst_i = 1'b0;
        for (int i = 1; i < `ID_NUM_REGS; i++) begin
            write_reg(5'(i), $urandom());
        end

        test_alu_decode();
        test_forwarding();
        test_load_use();
        test_branches();
        test_store_unknown_reset();

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== hw/id_stage_top.sv ====
`timescale 1ns/1ps

module id_stage_top
    import id_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  logic    inst_valid_i,
    input  word_t   pc_i,
    input  word_t   inst_i,
    input  reg_wr_t ex_fwd_i,
    input  alu_op_t ex_alu_op_i,
    input  reg_wr_t mem_fwd_i,
    input  reg_wr_t wb_i,
    output logic    stall_o,
    output branch_t branch_o,
    output logic    ex_valid_o,
    output id_ex_t  ex_o
);

    dec_ctrl_t ctrl;
    word_t     rdata_1;
    word_t     rdata_2;

    inst_decoder i_inst_decoder (
        .pc_i   (pc_i),
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .rst_i     (rst_i),
        .raddr_1_i (ctrl.rd_addr_1),
        .raddr_2_i (ctrl.rd_addr_2),
        .rdata_1_o (rdata_1),
        .rdata_2_o (rdata_2),
        .wb_i      (wb_i)
    );

    operand_resolve i_operand_resolve (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .ctrl_i       (ctrl),
        .rdata_1_i    (rdata_1),
        .rdata_2_i    (rdata_2),
        .ex_fwd_i     (ex_fwd_i),
        .mem_fwd_i    (mem_fwd_i),
        .ex_alu_op_i  (ex_alu_op_i),
        .stall_o      (stall_o),
        .branch_o     (branch_o),
        .ex_valid_o   (ex_valid_o),
        .ex_o         (ex_o)
    );

endmodule

// ==== hw/operand_resolve.sv ====
`timescale 1ns/1ps

module operand_resolve
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      inst_valid_i,
    input  dec_ctrl_t ctrl_i,
    input  word_t     rdata_1_i,
    input  word_t     rdata_2_i,
    input  reg_wr_t   ex_fwd_i,
    input  reg_wr_t   mem_fwd_i,
    input  alu_op_t   ex_alu_op_i,
    output logic      stall_o,
    output branch_t   branch_o,
    output logic      ex_valid_o,
    output id_ex_t    ex_o
);

    word_t  operand_1;
    word_t  operand_2;
    logic   load_use_1;
    logic   load_use_2;
    logic   cond;
    id_ex_t id_ex_next;

    // ex beats mem beats register file
    function automatic word_t pick(
        input logic      en,
        input reg_addr_t addr,
        input word_t     rdata,
        input word_t     imm,
        input reg_wr_t   ex,
        input reg_wr_t   mem
    );
        if (!en) begin
            return imm;
        end else if (ex.en && ex.addr == addr) begin
            return ex.data;
        end else if (mem.en && mem.addr == addr) begin
            return mem.data;
        end
        return rdata;
    endfunction

    assign operand_1 = pick(ctrl_i.rd_en_1, ctrl_i.rd_addr_1, rdata_1_i, ctrl_i.imm,
                            ex_fwd_i, mem_fwd_i);
    assign operand_2 = pick(ctrl_i.rd_en_2, ctrl_i.rd_addr_2, rdata_2_i, ctrl_i.imm,
                            ex_fwd_i, mem_fwd_i);

    // load in ex, data not ready until mem
    assign load_use_1 = ctrl_i.rd_en_1 && ex_alu_op_i == alu_lw &&
                        ex_fwd_i.addr == ctrl_i.rd_addr_1;
    assign load_use_2 = ctrl_i.rd_en_2 && ex_alu_op_i == alu_lw &&
                        ex_fwd_i.addr == ctrl_i.rd_addr_2;

    assign stall_o = !rst_i && inst_valid_i && (load_use_1 || load_use_2);

    always_comb begin
        case (ctrl_i.br_kind)
            br_beq:           cond = (operand_1 == operand_2);
            br_bne:           cond = (operand_1 != operand_2);
            br_jump, br_jreg: cond = 1'b1;
            default:          cond = 1'b0;
        endcase
    end

    assign branch_o.taken  = !rst_i && inst_valid_i && !stall_o && cond;
    assign branch_o.target = (ctrl_i.br_kind == br_jreg) ? operand_1 : ctrl_i.target;

    always_comb begin
        id_ex_next = '0;    // bubble
        if (inst_valid_i && !stall_o) begin
            id_ex_next.alu_op    = ctrl_i.alu_op;
            id_ex_next.alu_sel   = ctrl_i.alu_sel;
            id_ex_next.operand_1 = operand_1;
            id_ex_next.operand_2 = operand_2;
            id_ex_next.wr_en     = ctrl_i.wr_en;
            id_ex_next.wr_addr   = ctrl_i.wr_addr;
            id_ex_next.link_addr = ctrl_i.link_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o <= 1'b0;
            ex_o       <= '0;
        end else begin
            ex_valid_o <= inst_valid_i && !stall_o;
            ex_o       <= id_ex_next;
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`include "id_cfg.svh"

module reg_file
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  reg_addr_t raddr_1_i,
    input  reg_addr_t raddr_2_i,
    output word_t     rdata_1_o,
    output word_t     rdata_2_o,
    input  reg_wr_t   wb_i
);

    word_t regs [`ID_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            regs <= '{default: `ID_ZERO_WORD};
        end else if (wb_i.en && wb_i.addr != '0) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // r0 hardwired, same-cycle write passes straight through
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return `ID_ZERO_WORD;
        end else if (wb_i.en && wb_i.addr == addr) begin
            return wb_i.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata_1_o = read_port(raddr_1_i);
        rdata_2_o = read_port(raddr_2_i);
    end

endmodule

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps
`include "id_cfg.svh"

module inst_decoder
    import id_pkg::*;
(
    input  word_t     pc_i,
    input  word_t     inst_i,
    output dec_ctrl_t ctrl_o
);

    // instruction fields
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  shamt;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm16;

    word_t pc_plus_4;
    word_t pc_plus_8;
    word_t br_target;
    word_t jump_target;
    word_t i_imm;
    logic  shift_imm;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    assign pc_plus_4   = pc_i + 32'd4;
    assign pc_plus_8   = pc_i + 32'd8;
    assign br_target   = pc_plus_4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};   // 256 MB region

    assign shift_imm = (opcode == op_special) &&
                       (funct == fn_sll || funct == fn_srl || funct == fn_sra);

    // logic ops zero extend, lui takes the upper half
    always_comb begin
        case (opcode)
            op_ori, op_andi, op_xori: i_imm = {16'h0000, imm16};
            op_lui:                   i_imm = {imm16, 16'h0000};
            default:                  i_imm = {{16{imm16[15]}}, imm16};
        endcase
    end

    function automatic alu_op_t decode_op(input logic [5:0] opc, input logic [5:0] fn);
        alu_op_t op;
        op = alu_nop;
        case (opc)
            op_special: begin
                case (fn)
                    fn_or:           op = alu_or;
                    fn_and:          op = alu_and;
                    fn_nor:          op = alu_nor;
                    fn_addu:         op = alu_add;
                    fn_subu:         op = alu_sub;
                    fn_slt:          op = alu_slt;
                    fn_sll, fn_sllv: op = alu_sll;
                    fn_srl, fn_srlv: op = alu_srl;
                    fn_sra, fn_srav: op = alu_sra;
                    fn_jr:           op = alu_jr;
                    default:         op = alu_nop;
                endcase
            end
            op_ori, op_lui: op = alu_or;
            op_andi:        op = alu_and;
            op_xori:        op = alu_xor;
            op_addiu:       op = alu_add;
            op_slti:        op = alu_slt;
            op_lw:          op = alu_lw;
            op_sw:          op = alu_sw;
            op_beq:         op = alu_beq;
            op_bne:         op = alu_bne;
            op_j:           op = alu_j;
            op_jal:         op = alu_jal;
            default:        op = alu_nop;
        endcase
        return op;
    endfunction

    function automatic alu_sel_t sel_of(input alu_op_t op);
        case (op)
            alu_or, alu_and, alu_nor, alu_xor:   return sel_logic;
            alu_sll, alu_srl, alu_sra:           return sel_shift;
            alu_add, alu_sub, alu_slt:           return sel_arith;
            alu_lw, alu_sw:                      return sel_load_store;
            alu_beq, alu_bne, alu_j, alu_jal,
            alu_jr:                              return sel_jump_branch;
            default:                             return sel_nop;
        endcase
    endfunction

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.alu_op    = decode_op(opcode, funct);
        ctrl_o.alu_sel   = sel_of(ctrl_o.alu_op);
        ctrl_o.rd_addr_1 = rs;
        ctrl_o.rd_addr_2 = rt;
        ctrl_o.wr_addr   = rd;
        ctrl_o.br_kind   = br_none;
        ctrl_o.target    = br_target;
        ctrl_o.link_addr = `ID_ZERO_WORD;

        case (opcode)
            op_special: begin
                if (ctrl_o.alu_op != alu_nop) begin
                    ctrl_o.rd_en_1 = !shift_imm;    // shamt goes to operand_1
                    ctrl_o.rd_en_2 = (ctrl_o.alu_op != alu_jr);
                    ctrl_o.wr_en   = (ctrl_o.alu_op != alu_jr);
                    if (shift_imm) begin
                        ctrl_o.imm = word_t'(shamt);
                    end
                    if (ctrl_o.alu_op == alu_jr) begin
                        ctrl_o.br_kind = br_jreg;
                    end
                end
            end
            op_ori, op_andi, op_xori, op_lui, op_addiu, op_slti, op_lw: begin
                ctrl_o.rd_en_1 = 1'b1;
                ctrl_o.wr_en   = 1'b1;
                ctrl_o.wr_addr = rt;
                ctrl_o.imm     = i_imm;
            end
            op_sw: begin
                ctrl_o.rd_en_1 = 1'b1;
                ctrl_o.rd_en_2 = 1'b1;
                ctrl_o.imm     = i_imm;
            end
            op_beq, op_bne: begin
                ctrl_o.rd_en_1 = 1'b1;
                ctrl_o.rd_en_2 = 1'b1;
                ctrl_o.br_kind = (opcode == op_beq) ? br_beq : br_bne;
            end
            op_j: begin
                ctrl_o.br_kind = br_jump;
                ctrl_o.target  = jump_target;
            end
            op_jal: begin
                ctrl_o.br_kind   = br_jump;
                ctrl_o.target    = jump_target;
                ctrl_o.wr_en     = 1'b1;
                ctrl_o.wr_addr   = reg_addr_t'(`ID_LINK_REG);
                ctrl_o.link_addr = pc_plus_8;
            end
            default: ;      // unknown opcode, valid no-op
        endcase
    end

endmodule

// ==== hw/id_pkg.sv ====
`include "id_cfg.svh"

package id_pkg;

    typedef logic [`ID_DATA_W-1:0] word_t;
    typedef logic [`ID_REG_AW-1:0] reg_addr_t;

    // primary opcodes, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // special function field, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_sllv = 6'h04,
        fn_srlv = 6'h06,
        fn_srav = 6'h07,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [4:0] {
        alu_nop, alu_or, alu_and, alu_nor, alu_xor, alu_add, alu_sub, alu_slt,
        alu_sll, alu_srl, alu_sra, alu_lw, alu_sw, alu_beq, alu_bne, alu_j,
        alu_jal, alu_jr
    } alu_op_t;

    typedef enum logic [2:0] {
        sel_nop, sel_logic, sel_shift, sel_arith, sel_jump_branch, sel_load_store
    } alu_sel_t;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_jump, br_jreg   // br_jump covers j and jal
    } br_kind_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_wr_t;

    typedef struct packed {
        alu_op_t   alu_op;
        alu_sel_t  alu_sel;
        logic      rd_en_1;
        reg_addr_t rd_addr_1;
        logic      rd_en_2;
        reg_addr_t rd_addr_2;
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     imm;
        br_kind_t  br_kind;
        word_t     target;       // static branch/jump target
        word_t     link_addr;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_t   alu_op;
        alu_sel_t  alu_sel;
        word_t     operand_1;
        word_t     operand_2;
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     link_addr;
    } id_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

endpackage

// ==== include/id_cfg.svh ====
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// datapath and register file sizes
`define ID_DATA_W     32
`define ID_REG_AW     5
`define ID_NUM_REGS   32

`define ID_LINK_REG   31            // jal destination

// reset and zero values
`define ID_ZERO_WORD  32'h0000_0000

`endif
